//--- hdl/mpq_pkg.sv
package mpq_pkg;

    // queue geometry
    localparam int unsigned NUM_MPQ     = 4;
    localparam int unsigned MPQ_IDX_W   = $clog2(NUM_MPQ);
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // the in-flight count can run ahead of the queue depth, so leave headroom
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH) + 6;

    localparam int unsigned ADDR_W  = 32;
    localparam int unsigned SIZE_W  = 16;

    // message id as seen on the HER and feedback ports, low bits pick the MPQ
    localparam int unsigned MSGID_W = 8;

    typedef enum logic [2:0] {
        Free,
        Header,
        HeaderRunning,
        Payload,
        PayloadDraining,
        Completion,
        CompletionRunning
    } mpq_lstate_t;

    typedef struct packed {
        logic [ADDR_W-1:0] hh_addr;
        logic [SIZE_W-1:0] hh_size;
        logic [ADDR_W-1:0] ph_addr;
        logic [SIZE_W-1:0] ph_size;
        logic [ADDR_W-1:0] th_addr;
        logic [SIZE_W-1:0] th_size;
    } mpq_meta_t;

    typedef struct packed {
        logic [ADDR_W-1:0] pkt_addr;
        logic [SIZE_W-1:0] pkt_size;
    } mpq_pkt_t;

    typedef struct packed {
        mpq_lstate_t      lstate;
        logic [CNT_W-1:0] length;
        logic [CNT_W-1:0] in_flight;
        logic             eom_seen;
        logic             has_completion;
    } mpq_t;

    typedef struct packed {
        logic [MPQ_IDX_W-1:0] msg_idx;
        logic [ADDR_W-1:0]    handler_addr;
        logic [SIZE_W-1:0]    handler_size;
        logic [ADDR_W-1:0]    pkt_addr;
        logic [SIZE_W-1:0]    pkt_size;
    } handler_task_t;

endpackage

//--- hdl/packet_queues.sv
module packet_queues
    import mpq_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push_i,
    input  logic [MPQ_IDX_W-1:0] push_idx_i,
    input  mpq_pkt_t             push_pkt_i,
    input  logic                 pop_i,
    input  logic [MPQ_IDX_W-1:0] pop_idx_i,
    output mpq_pkt_t             head_o,
    output logic [NUM_MPQ-1:0]   full_o
);

    logic [NUM_MPQ-1:0][QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [NUM_MPQ-1:0][QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [NUM_MPQ-1:0][QUEUE_PTR_W:0]   count_q;
    logic [NUM_MPQ-1:0]                  push_en;
    logic [NUM_MPQ-1:0]                  pop_en;

    mpq_pkt_t slots_q [NUM_MPQ][QUEUE_DEPTH];

    function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] ptr);
        return (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // decode the push and pop ports per queue
    always_comb begin
        for (int i = 0; i < NUM_MPQ; i++) begin
            push_en[i] = push_i && (push_idx_i == MPQ_IDX_W'(i));
            pop_en[i]  = pop_i && (pop_idx_i == MPQ_IDX_W'(i));
            full_o[i]  = (count_q[i] == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            for (int i = 0; i < NUM_MPQ; i++) begin
                if (push_en[i]) begin
                    wr_ptr_q[i] <= next_ptr(wr_ptr_q[i]);
                end
                if (pop_en[i]) begin
                    rd_ptr_q[i] <= next_ptr(rd_ptr_q[i]);
                end
                // push and pop together leave the fill level alone
                if (push_en[i] && !pop_en[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end else if (!push_en[i] && pop_en[i]) begin
                    count_q[i] <= count_q[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            slots_q[push_idx_i][wr_ptr_q[push_idx_i]] <= push_pkt_i;
        end
    end

    // head of the queue being looked at by the arbiter
    assign head_o = slots_q[pop_idx_i][rd_ptr_q[pop_idx_i]];

endmodule

//--- hdl/mpq_fsm.sv
module mpq_fsm
    import mpq_pkg::*;
(
    input  logic her_new_i,
    input  logic task_sent_i,
    input  logic feedback_i,
    input  logic her_has_hh_i,
    input  logic her_has_th_i,
    input  logic her_eom_i,
    input  mpq_t mpq_i,
    output mpq_t mpq_o,
    output logic update_o
);

    logic pkt_push;
    logic pkt_issue;

    assign pkt_push  = her_new_i;
    // only payload tasks consume a counted packet
    assign pkt_issue = task_sent_i && (mpq_i.lstate == Payload);
    assign update_o  = her_new_i || task_sent_i || feedback_i;

    always_comb begin
        mpq_o = mpq_i;

        case ({pkt_push, pkt_issue})
            2'b10:   mpq_o.length = mpq_i.length + 1'b1;
            2'b01:   mpq_o.length = mpq_i.length - 1'b1;
            default: mpq_o.length = mpq_i.length;
        endcase

        case ({task_sent_i, feedback_i})
            2'b10:   mpq_o.in_flight = mpq_i.in_flight + 1'b1;
            2'b01:   mpq_o.in_flight = mpq_i.in_flight - 1'b1;
            default: mpq_o.in_flight = mpq_i.in_flight;
        endcase

        if (her_new_i && her_eom_i) begin
            mpq_o.eom_seen = 1'b1;
        end

        case (mpq_i.lstate)
            Free: begin
                // first HER opens the message
                if (her_new_i) begin
                    mpq_o.lstate         = her_has_hh_i ? Header : Payload;
                    mpq_o.has_completion = her_has_th_i;
                end
            end
            Header: begin
                if (task_sent_i) begin
                    mpq_o.lstate = HeaderRunning;
                end
            end
            HeaderRunning: begin
                // payloads wait until the header handler has finished
                if (feedback_i) begin
                    mpq_o.lstate = Payload;
                end
            end
            Payload: begin
                if (task_sent_i && mpq_i.eom_seen && (mpq_i.length == CNT_W'(1))) begin
                    mpq_o.lstate = PayloadDraining;
                end
            end
            PayloadDraining: begin
                if (feedback_i && (mpq_i.in_flight == CNT_W'(1))) begin
                    mpq_o.lstate = mpq_i.has_completion ? Completion : Free;
                end
            end
            Completion: begin
                if (task_sent_i) begin
                    mpq_o.lstate = CompletionRunning;
                end
            end
            CompletionRunning: begin
                if (feedback_i) begin
                    mpq_o.lstate = Free;
                end
            end
            default: mpq_o.lstate = Free;
        endcase

        // a finished message leaves no flags behind for the next one on this queue
        if ((mpq_i.lstate != Free) && (mpq_o.lstate == Free)) begin
            mpq_o.eom_seen       = 1'b0;
            mpq_o.has_completion = 1'b0;
        end
    end

endmodule

//--- hdl/mpq_meta_store.sv
module mpq_meta_store
    import mpq_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 we_i,
    input  logic [MPQ_IDX_W-1:0] waddr_i,
    input  mpq_meta_t            wdata_i,
    input  logic                 re_i,
    input  logic [MPQ_IDX_W-1:0] raddr_i,
    output mpq_meta_t            rdata_o
);

    mpq_meta_t entries_q [NUM_MPQ];
    mpq_meta_t rdata_q;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            entries_q[waddr_i] <= wdata_i;
        end
    end

    // read data shows up one cycle after the read and holds until the next one
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (re_i) begin
            rdata_q <= entries_q[raddr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- hdl/mpq_rr_arbiter.sv
module mpq_rr_arbiter
    import mpq_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [NUM_MPQ-1:0]   req_i,
    input  logic                 gnt_i,
    output logic                 valid_o,
    output logic [MPQ_IDX_W-1:0] idx_o
);

    logic [MPQ_IDX_W-1:0] last_q;
    logic [MPQ_IDX_W-1:0] lock_idx_q;
    logic                 lock_q;
    logic [MPQ_IDX_W-1:0] pick_idx;
    logic                 pick_valid;

    // search starts just after the last granted queue
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = last_q;
        for (int k = 1; k <= NUM_MPQ; k++) begin
            cand = (int'(last_q) + k) % NUM_MPQ;
            if (!pick_valid && req_i[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = MPQ_IDX_W'(cand);
            end
        end
    end

    // an offered choice stays put until it is taken
    assign valid_o = lock_q || pick_valid;
    assign idx_o   = lock_q ? lock_idx_q : pick_idx;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q     <= MPQ_IDX_W'(NUM_MPQ - 1);
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q     <= valid_o && !gnt_i;
            lock_idx_q <= idx_o;
            if (valid_o && gnt_i) begin
                last_q <= idx_o;
            end
        end
    end

endmodule

//--- hdl/task_issue.sv
module task_issue
    import mpq_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 arb_valid_i,
    input  logic [MPQ_IDX_W-1:0] arb_idx_i,
    output logic                 arb_ready_o,
    input  mpq_lstate_t          lstate_i,
    input  mpq_meta_t            meta_i,
    input  mpq_pkt_t             head_i,
    input  logic                 task_ready_i,
    output logic                 task_valid_o,
    output handler_task_t        task_o
);

    typedef enum logic [1:0] {Idle, Ready, Stalled} issue_state_t;

    issue_state_t         state_q;
    issue_state_t         state_d;
    logic                 grant;
    logic [MPQ_IDX_W-1:0] sel_idx_q;
    mpq_lstate_t          sel_lstate_q;
    mpq_pkt_t             sel_pkt_q;
    handler_task_t        new_task;
    handler_task_t        task_q;

    // a new grant is taken when the output slot is empty or being drained
    assign arb_ready_o = (state_q == Idle) || task_ready_i;
    assign grant       = arb_valid_i && arb_ready_o;

    always_comb begin
        if (grant) begin
            state_d = Ready;
        end else if ((state_q != Idle) && !task_ready_i) begin
            state_d = Stalled;
        end else begin
            state_d = Idle;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= Idle;
            sel_idx_q    <= '0;
            sel_lstate_q <= Free;
        end else begin
            state_q <= state_d;
            if (grant) begin
                sel_idx_q    <= arb_idx_i;
                sel_lstate_q <= lstate_i;
            end
        end
    end

    // the head moves on with the pop, so take a copy at grant time
    always_ff @(posedge clk_i) begin
        if (grant) begin
            sel_pkt_q <= head_i;
        end
        task_q <= task_o;
    end

    // meta_i arrives one cycle after the grant, in step with the Ready state
    always_comb begin
        new_task.msg_idx  = sel_idx_q;
        new_task.pkt_addr = sel_pkt_q.pkt_addr;
        new_task.pkt_size = sel_pkt_q.pkt_size;
        case (sel_lstate_q)
            Header: begin
                new_task.handler_addr = meta_i.hh_addr;
                new_task.handler_size = meta_i.hh_size;
            end
            Completion: begin
                new_task.handler_addr = meta_i.th_addr;
                new_task.handler_size = meta_i.th_size;
            end
            default: begin
                new_task.handler_addr = meta_i.ph_addr;
                new_task.handler_size = meta_i.ph_size;
            end
        endcase
    end

    assign task_valid_o = (state_q != Idle);
    assign task_o       = (state_q == Ready) ? new_task : task_q;

endmodule

//--- hdl/mpq_engine.sv
module mpq_engine
    import mpq_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               her_valid_i,
    input  logic [MSGID_W-1:0] her_msgid_i,
    input  mpq_pkt_t           her_pkt_i,
    input  logic               her_eom_i,
    input  mpq_meta_t          her_meta_i,
    output logic               her_ready_o,
    input  logic               feedback_valid_i,
    input  logic [MSGID_W-1:0] feedback_msgid_i,
    input  logic               task_ready_i,
    output logic               task_valid_o,
    output handler_task_t      task_o
);

    mpq_t [NUM_MPQ-1:0]   mpq_q;
    mpq_t [NUM_MPQ-1:0]   mpq_d;
    logic [MPQ_IDX_W-1:0] her_idx;
    logic [MPQ_IDX_W-1:0] fb_idx;
    logic [MPQ_IDX_W-1:0] arb_idx;
    logic                 her_accept;
    logic                 grant;
    logic                 arb_valid;
    logic                 arb_ready;
    logic                 pop;
    logic                 last_pkt;
    logic                 her_has_hh;
    logic                 her_has_th;
    logic [NUM_MPQ-1:0]   full;
    logic [NUM_MPQ-1:0]   mpq_ready;
    mpq_pkt_t             head;
    mpq_meta_t            meta_rd;
    mpq_t                 her_fsm_s;
    mpq_t                 sent_fsm_s;
    mpq_t                 fb_fsm_s;
    logic                 her_upd;
    logic                 sent_upd;
    logic                 fb_upd;

    assign her_idx    = her_msgid_i[MPQ_IDX_W-1:0];
    assign fb_idx     = feedback_msgid_i[MPQ_IDX_W-1:0];
    assign her_ready_o = !full[her_idx];
    assign her_accept = her_valid_i && her_ready_o;
    assign grant      = arb_valid && arb_ready;
    assign her_has_hh = (her_meta_i.hh_addr != '0);
    assign her_has_th = (her_meta_i.th_addr != '0);

    // the EOM packet stays queued when a completion task still needs it
    assign last_pkt = mpq_q[arb_idx].eom_seen && (mpq_q[arb_idx].length == CNT_W'(1));
    assign pop = grant && (((mpq_q[arb_idx].lstate == Payload) &&
                            !(last_pkt && mpq_q[arb_idx].has_completion)) ||
                           (mpq_q[arb_idx].lstate == Completion));

    packet_queues u_packet_queues (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .push_i     (her_accept),
        .push_idx_i (her_idx),
        .push_pkt_i (her_pkt_i),
        .pop_i      (pop),
        .pop_idx_i  (arb_idx),
        .head_o     (head),
        .full_o     (full)
    );

    mpq_meta_store u_meta_store (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .we_i    (her_accept && (mpq_q[her_idx].lstate == Free)),
        .waddr_i (her_idx),
        .wdata_i (her_meta_i),
        .re_i    (grant),
        .raddr_i (arb_idx),
        .rdata_o (meta_rd)
    );

    always_comb begin
        for (int i = 0; i < NUM_MPQ; i++) begin
            mpq_ready[i] = (mpq_q[i].lstate == Header) || (mpq_q[i].lstate == Completion) ||
                           ((mpq_q[i].lstate == Payload) && (mpq_q[i].length != '0));
        end
    end

    mpq_rr_arbiter u_arbiter (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (mpq_ready),
        .gnt_i   (arb_ready),
        .valid_o (arb_valid),
        .idx_o   (arb_idx)
    );

    task_issue u_task_issue (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .arb_valid_i  (arb_valid),
        .arb_idx_i    (arb_idx),
        .arb_ready_o  (arb_ready),
        .lstate_i     (mpq_q[arb_idx].lstate),
        .meta_i       (meta_rd),
        .head_i       (head),
        .task_ready_i (task_ready_i),
        .task_valid_o (task_valid_o),
        .task_o       (task_o)
    );

    // up to three queues move per cycle, each view sees every event on its own index
    mpq_fsm u_her_fsm (
        .her_new_i    (her_accept),
        .task_sent_i  (grant && (arb_idx == her_idx)),
        .feedback_i   (feedback_valid_i && (fb_idx == her_idx)),
        .her_has_hh_i (her_has_hh),
        .her_has_th_i (her_has_th),
        .her_eom_i    (her_eom_i),
        .mpq_i        (mpq_q[her_idx]),
        .mpq_o        (her_fsm_s),
        .update_o     (her_upd)
    );

    mpq_fsm u_sent_fsm (
        .her_new_i    (her_accept && (her_idx == arb_idx)),
        .task_sent_i  (grant),
        .feedback_i   (feedback_valid_i && (fb_idx == arb_idx)),
        .her_has_hh_i (her_has_hh),
        .her_has_th_i (her_has_th),
        .her_eom_i    (her_eom_i),
        .mpq_i        (mpq_q[arb_idx]),
        .mpq_o        (sent_fsm_s),
        .update_o     (sent_upd)
    );

    mpq_fsm u_fb_fsm (
        .her_new_i    (her_accept && (her_idx == fb_idx)),
        .task_sent_i  (grant && (arb_idx == fb_idx)),
        .feedback_i   (feedback_valid_i),
        .her_has_hh_i (her_has_hh),
        .her_has_th_i (her_has_th),
        .her_eom_i    (her_eom_i),
        .mpq_i        (mpq_q[fb_idx]),
        .mpq_o        (fb_fsm_s),
        .update_o     (fb_upd)
    );

    // views sharing an index compute the same result, so write order is free
    always_comb begin
        mpq_d = mpq_q;
        if (her_upd) begin
            mpq_d[her_idx] = her_fsm_s;
        end
        if (sent_upd) begin
            mpq_d[arb_idx] = sent_fsm_s;
        end
        if (fb_upd) begin
            mpq_d[fb_idx] = fb_fsm_s;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mpq_q <= '0;
        end else begin
            mpq_q <= mpq_d;
        end
    end

endmodule

//--- testbench/mpq_engine_assert.sv
module mpq_engine_assert
    import mpq_pkg::*;
(
    input logic                              clk_i,
    input logic                              rst_ni,
    input logic                              pop_i,
    input logic [MPQ_IDX_W-1:0]              pop_idx_i,
    input logic [NUM_MPQ-1:0][QUEUE_PTR_W:0] fifo_count_i,
    input logic                              task_valid_i,
    input logic                              task_ready_i,
    input handler_task_t                     task_i
);

    int fail_cnt = 0;

    // a stalled task stays valid and does not move
    a_task_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (task_valid_i && !task_ready_i) |=> (task_valid_i && $stable(task_i)))
        else begin
            fail_cnt++;
            $error("task_o changed or dropped while the scheduler stalled it");
        end

    // the length counter and the packet FIFO fill level agree on every pop
    a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> (fifo_count_i[pop_idx_i] != '0))
        else begin
            fail_cnt++;
            $error("pop issued on an empty packet queue");
        end

    a_task_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        task_valid_i |-> !$isunknown(task_i))
        else begin
            fail_cnt++;
            $error("task_o has unknown bits while valid");
        end

endmodule

bind mpq_engine mpq_engine_assert u_engine_assert (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pop_i        (pop),
    .pop_idx_i    (arb_idx),
    .fifo_count_i (u_packet_queues.count_q),
    .task_valid_i (task_valid_o),
    .task_ready_i (task_ready_i),
    .task_i       (task_o)
);

//--- testbench/mpq_model.svh
`ifndef MPQ_MODEL_SVH
`define MPQ_MODEL_SVH

localparam int MAX_PKTS  = 6;
localparam int MAX_TASKS = MAX_PKTS + 2;

// message currently open on each id, as generated by the stimulus
mpq_meta_t     msg_meta [NUM_MPQ];
mpq_pkt_t      msg_pkt  [NUM_MPQ][MAX_PKTS];
int            msg_len  [NUM_MPQ];

// expected tasks per id in issue order, exp_pops marks those that free a queue slot
handler_task_t exp_task [NUM_MPQ][MAX_TASKS];
logic          exp_pops [NUM_MPQ][MAX_TASKS];
int            exp_rd   [NUM_MPQ];
int            exp_wr   [NUM_MPQ];

// packets the DUT took in that no transferred task has released yet
int            held_cnt [NUM_MPQ];

task automatic add_expected(input int id, input logic [ADDR_W-1:0] h_addr,
                            input logic [SIZE_W-1:0] h_size, input mpq_pkt_t pkt,
                            input logic pops);
    handler_task_t t;
    t.msg_idx      = MPQ_IDX_W'(id);
    t.handler_addr = h_addr;
    t.handler_size = h_size;
    t.pkt_addr     = pkt.pkt_addr;
    t.pkt_size     = pkt.pkt_size;
    exp_task[id][exp_wr[id]] = t;
    exp_pops[id][exp_wr[id]] = pops;
    exp_wr[id]++;
endtask

// header on the first packet, one payload per packet, completion on the EOM packet
task automatic build_expected(input int id);
    mpq_meta_t m;
    logic      has_th;
    int        last;
    m          = msg_meta[id];
    has_th     = (m.th_addr != '0);
    last       = msg_len[id] - 1;
    exp_rd[id] = 0;
    exp_wr[id] = 0;
    if (m.hh_addr != '0) begin
        add_expected(id, m.hh_addr, m.hh_size, msg_pkt[id][0], 1'b0);
    end
    for (int i = 0; i <= last; i++) begin
        // with a completion pending the EOM packet stays queued for it
        add_expected(id, m.ph_addr, m.ph_size, msg_pkt[id][i], !(has_th && (i == last)));
    end
    if (has_th) begin
        add_expected(id, m.th_addr, m.th_size, msg_pkt[id][last], 1'b1);
    end
endtask

function automatic logic all_drained();
    logic ok;
    ok = 1'b1;
    for (int id = 0; id < NUM_MPQ; id++) begin
        if ((exp_rd[id] != exp_wr[id]) || (held_cnt[id] != 0)) begin
            ok = 1'b0;
        end
    end
    return ok;
endfunction

`endif

//--- testbench/tb_mpq_engine.sv
module tb_mpq_engine
    import mpq_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_MSG    = 24;

    logic               clk_i;
    logic               rst_ni;
    logic               her_valid_i;
    logic [MSGID_W-1:0] her_msgid_i;
    mpq_pkt_t           her_pkt_i;
    logic               her_eom_i;
    mpq_meta_t          her_meta_i;
    logic               her_ready_o;
    logic               feedback_valid_i;
    logic [MSGID_W-1:0] feedback_msgid_i;
    logic               task_ready_i;
    logic               task_valid_o;
    handler_task_t      task_o;

    `include "mpq_model.svh"

    localparam int WATCHDOG_CYCLES = NUM_MSG * MAX_TASKS * 50;

    logic [31:0] rng_state = 32'ha36caca1;
    int          cycle;
    int          msgs_started;
    int          msgs_done;
    logic        her_taken;
    logic        msg_open       [NUM_MPQ];
    int          send_idx       [NUM_MPQ];
    int          fb_outstanding [NUM_MPQ];
    int          fb_id_q  [$];
    int          fb_due_q [$];

    mpq_engine DUT (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .her_valid_i      (her_valid_i),
        .her_msgid_i      (her_msgid_i),
        .her_pkt_i        (her_pkt_i),
        .her_eom_i        (her_eom_i),
        .her_meta_i       (her_meta_i),
        .her_ready_o      (her_ready_o),
        .feedback_valid_i (feedback_valid_i),
        .feedback_msgid_i (feedback_msgid_i),
        .task_ready_i     (task_ready_i),
        .task_valid_o     (task_valid_o),
        .task_o           (task_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = next_random();
        return (r >> 8) % n;
    endfunction

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        stop_on_error();
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_task(input string name, input handler_task_t got,
                              input handler_task_t want);
        if (got !== want) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_pkt(input string name, input mpq_pkt_t got, input mpq_pkt_t want);
        if (got !== want) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
            stop_on_error();
        end
    endtask

    // random metadata, a zero handler address means no such handler
    task automatic open_message(input int id);
        msg_meta[id].hh_addr = (rand_below(2) != 0) ? next_random() : '0;
        msg_meta[id].hh_size = SIZE_W'(next_random());
        msg_meta[id].ph_addr = next_random() | 32'h1;
        msg_meta[id].ph_size = SIZE_W'(next_random());
        msg_meta[id].th_addr = (rand_below(2) != 0) ? next_random() : '0;
        msg_meta[id].th_size = SIZE_W'(next_random());
        msg_len[id] = 1 + int'(rand_below(MAX_PKTS));
        for (int i = 0; i < msg_len[id]; i++) begin
            msg_pkt[id][i].pkt_addr = next_random();
            msg_pkt[id][i].pkt_size = SIZE_W'(next_random());
        end
        send_idx[id] = 0;
        msg_open[id] = 1'b1;
        msgs_started++;
        build_expected(id);
    endtask

    task automatic take_task(input handler_task_t got);
        int            id;
        handler_task_t want;
        mpq_pkt_t      got_pkt;
        mpq_pkt_t      want_pkt;
        id = int'(got.msg_idx);
        if (exp_rd[id] == exp_wr[id]) begin
            report_problem($sformatf("task for queue %0d arrived with none expected", id));
        end
        want              = exp_task[id][exp_rd[id]];
        got_pkt.pkt_addr  = got.pkt_addr;
        got_pkt.pkt_size  = got.pkt_size;
        want_pkt.pkt_addr = want.pkt_addr;
        want_pkt.pkt_size = want.pkt_size;
        check_pkt("task_o packet", got_pkt, want_pkt);
        check_task("task_o", got, want);
        if (exp_pops[id][exp_rd[id]]) begin
            held_cnt[id]--;
        end
        exp_rd[id]++;
        fb_outstanding[id]++;
        fb_id_q.push_back(id);
        fb_due_q.push_back(cycle + 1 + int'(rand_below(8)));
    endtask

    // everything the DUT did at this rising edge
    task automatic sample_cycle();
        int   id;
        logic slack;
        cycle++;
        if (DUT.u_engine_assert.fail_cnt != 0) begin
            report_problem("a concurrent assertion on the DUT failed");
        end
        if (feedback_valid_i) begin
            fb_outstanding[int'(feedback_msgid_i[MPQ_IDX_W-1:0])]--;
        end
        if (task_valid_o && task_ready_i) begin
            take_task(task_o);
        end
        if (her_valid_i && her_ready_o) begin
            id = int'(her_msgid_i[MPQ_IDX_W-1:0]);
            // a stalled task already freed its slot when it was granted
            slack = task_valid_o && !task_ready_i && (int'(task_o.msg_idx) == id) &&
                    (exp_rd[id] != exp_wr[id]) && exp_pops[id][exp_rd[id]];
            if ((held_cnt[id] - int'(slack)) >= int'(QUEUE_DEPTH)) begin
                report_problem($sformatf("HER accepted on queue %0d while it was full", id));
            end
            held_cnt[id]++;
            send_idx[id]++;
            her_taken = 1'b1;
        end
    endtask

    task automatic drive_her();
        int start;
        int id;
        int pick;
        pick = -1;
        if (!her_valid_i || her_taken) begin
            her_valid_i = 1'b0;
            start = int'(rand_below(NUM_MPQ));
            for (int k = 0; k < NUM_MPQ; k++) begin
                id = (start + k) % NUM_MPQ;
                if ((pick < 0) && msg_open[id] && (send_idx[id] < msg_len[id])) begin
                    pick = id;
                end
            end
            if ((pick >= 0) && (rand_below(4) != 0)) begin
                her_valid_i = 1'b1;
                her_msgid_i = MSGID_W'(next_random());
                her_msgid_i[MPQ_IDX_W-1:0] = MPQ_IDX_W'(pick);
                her_pkt_i  = msg_pkt[pick][send_idx[pick]];
                her_eom_i  = (send_idx[pick] == msg_len[pick] - 1);
                her_meta_i = msg_meta[pick];
            end
        end
        her_taken = 1'b0;
    endtask

    task automatic drive_feedback();
        feedback_valid_i = 1'b0;
        if ((fb_id_q.size() > 0) && (fb_due_q[0] <= cycle)) begin
            feedback_valid_i = 1'b1;
            feedback_msgid_i = MSGID_W'(next_random());
            feedback_msgid_i[MPQ_IDX_W-1:0] = MPQ_IDX_W'(fb_id_q[0]);
            void'(fb_id_q.pop_front());
            void'(fb_due_q.pop_front());
        end
    endtask

    task automatic drive_cycle();
        // an id is reused only once its last feedback has been taken
        for (int id = 0; id < NUM_MPQ; id++) begin
            if (msg_open[id] && (send_idx[id] == msg_len[id]) &&
                (exp_rd[id] == exp_wr[id]) && (fb_outstanding[id] == 0)) begin
                msg_open[id] = 1'b0;
                msgs_done++;
            end
        end
        for (int id = 0; id < NUM_MPQ; id++) begin
            if (!msg_open[id] && (msgs_started < NUM_MSG) && (rand_below(4) == 0)) begin
                open_message(id);
            end
        end
        drive_her();
        drive_feedback();
        task_ready_i = (rand_below(3) != 0);
    endtask

    initial begin
        rst_ni           = 1'b0;
        her_valid_i      = 1'b0;
        her_msgid_i      = '0;
        her_pkt_i        = '0;
        her_eom_i        = 1'b0;
        her_meta_i       = '0;
        feedback_valid_i = 1'b0;
        feedback_msgid_i = '0;
        task_ready_i     = 1'b0;
        her_taken        = 1'b0;
        cycle            = 0;
        msgs_started     = 0;
        msgs_done        = 0;
        for (int id = 0; id < NUM_MPQ; id++) begin
            msg_open[id]       = 1'b0;
            send_idx[id]       = 0;
            fb_outstanding[id] = 0;
            msg_len[id]        = 0;
            exp_rd[id]         = 0;
            exp_wr[id]         = 0;
            held_cnt[id]       = 0;
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_flag("task_valid_o", task_valid_o, 1'b0);
        check_flag("her_ready_o", her_ready_o, 1'b1);
        while (msgs_done < NUM_MSG) begin
            @(posedge clk_i);
            sample_cycle();
            @(negedge clk_i);
            drive_cycle();
        end
        if (all_drained() && (fb_id_q.size() == 0) &&
            (DUT.u_engine_assert.fail_cnt == 0)) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_problem("run ended with leftover work or a failed assertion");
        end
    end

    // bound on the whole run, every task of every message gets a generous slice
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_problem($sformatf("watchdog expired with %0d of %0d messages finished",
                                 msgs_done, NUM_MSG));
    end

endmodule

//--- build.f
+incdir+testbench
hdl/mpq_pkg.sv
hdl/packet_queues.sv
hdl/mpq_fsm.sv
hdl/mpq_meta_store.sv
hdl/mpq_rr_arbiter.sv
hdl/task_issue.sv
hdl/mpq_engine.sv
testbench/mpq_engine_assert.sv
testbench/tb_mpq_engine.sv
